// File: src.f
src/rv_pkg.sv
src/decode_if.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu.sv
src/exec_top.sv
dv/clk_gen.sv
dv/exec_assertions.sv
dv/tb_exec.sv

// File: run.sh
#!/bin/bash
# build and run with Verilator, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_exec -o sim_exec \
   && ./obj_dir/sim_exec | tee /dev/stderr | grep -qx "NO ERRORS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: dv/tb_exec.sv
`default_nettype none

module tb_exec
   import rv_pkg::*;
   ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int n_rand = 60;
   // upper bound on issued instructions over all tests
   localparam int n_issue_max = 442;

   logic        clk;
   logic        rst_n;
   logic        issue;
   logic [31:0] instr_word;
   logic [31:0] pc;
   logic        done;
   logic [31:0] result;
   logic [4:0]  rd;
   logic        illegal;

   integer      seed = 32'he1b4908c;
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   bit          gaps = 1'b1;
   logic [31:0] pc_v = '0;
   logic [31:0] mirror [32];
   logic [31:0] exp_res_q [$];
   logic [4:0]  exp_rd_q [$];
   logic        exp_ill_q [$];
   logic [2:0]  br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
   logic [2:0]  ld_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};

   clk_gen u_clk (.clk(clk));

   exec_top DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .issue      (issue),
      .instr_word (instr_word),
      .pc         (pc),
      .done       (done),
      .result     (result),
      .rd         (rd),
      .illegal    (illegal)
   );

   function automatic logic [31:0] rnd();
      return $random(seed);
   endfunction

   function automatic logic [4:0] pick_reg();
      return 5'($unsigned($random(seed)) % 32);
   endfunction

   function automatic logic [4:0] pick_nz();
      return 5'(1 + $unsigned($random(seed)) % 31);
   endfunction

   function automatic logic [31:0] sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd_a);
      return {f7, rs2, rs1, f3, rd_a, opc_op};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd_a,
                                         input logic [6:0] opc);
      return {imm, rs1, f3, rd_a, opc};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd_a);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd_a, opc_jal};
   endfunction

   // base integer ops, alt selects sub and sra
   function automatic logic [31:0] ref_int(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
      int sa;
      int sb;
      sa = a;
      sb = b;
      case (f3)
         f3_add:  return alt ? a - b : a + b;
         f3_sll:  return a << b[4:0];
         f3_slt:  return {31'b0, sa < sb};
         f3_sltu: return {31'b0, a < b};
         f3_xor:  return a ^ b;
         f3_sr:   return alt ? 32'(sa >>> b[4:0]) : a >> b[4:0];
         f3_or:   return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic [31:0] ref_m(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
      longint sa;
      longint sb;
      longint ua;
      longint ub;
      longint p;
      int     si;
      int     ti;
      si = a;
      ti = b;
      sa = longint'(si);
      sb = longint'(ti);
      ua = {32'b0, a};
      ub = {32'b0, b};
      case (f3)
         f3_mul:    p = sa * sb;
         f3_mulh:   p = sa * sb;
         f3_mulhsu: p = sa * ub;
         f3_mulhu:  p = ua * ub;
         default:   p = 0;
      endcase
      case (f3)
         f3_mul:  return p[31:0];
         f3_div:  return (b == 0) ? '1 : (a == 32'h8000_0000 && b == '1) ? a : 32'(si / ti);
         f3_rem:  return (b == 0) ? a : (a == 32'h8000_0000 && b == '1) ? '0 : 32'(si % ti);
         f3_divu: return (b == 0) ? '1 : a / b;
         f3_remu: return (b == 0) ? a : a % b;
         default: return p[63:32];
      endcase
   endfunction

   function automatic logic ref_br(input logic [2:0] f3, input logic [31:0] a,
                                   input logic [31:0] b);
      int sa;
      int sb;
      sa = a;
      sb = b;
      case (f3)
         f3_beq:  return a == b;
         f3_bne:  return a != b;
         f3_blt:  return sa < sb;
         f3_bge:  return sa >= sb;
         f3_bltu: return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic send(input logic [31:0] word, input logic [31:0] exp,
                       input logic ill, input logic wr);
      logic [4:0] rd_f;
      int         gap;
      rd_f = word[11:7];
      exp_res_q.push_back(exp);
      exp_rd_q.push_back(rd_f);
      exp_ill_q.push_back(ill);
      if (wr && rd_f != 5'd0) begin
         mirror[rd_f] = exp;
      end
      @(posedge clk);
      issue      <= 1'b1;
      instr_word <= word;
      pc         <= pc_v;
      if (gaps) begin
         gap = $unsigned($random(seed)) % 3;
         repeat (gap) begin
            @(posedge clk);
            issue <= 1'b0;
         end
      end
   endtask

   task automatic finish_test(input string name, input int err_before);
      @(posedge clk);
      issue <= 1'b0;
      while (exp_res_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (2) @(posedge clk);
      tests++;
      if (errors == err_before) begin
         $display("test %s passed", name);
      end else begin
         $display("test %s failed with %0d errors", name, errors - err_before);
      end
   endtask

   // outputs are stable at the falling edge
   always @(negedge clk) begin
      if (rst_n && done) begin
         if (exp_res_q.size() == 0) begin
            $display("done pulsed with no instruction outstanding at %0t", $time);
            errors++;
         end else begin
            checks++;
            if (result !== exp_res_q[0]) begin
               $display("ERROR %0t result exp %h got %h", $time, exp_res_q[0], result);
               errors++;
            end
            if (rd !== exp_rd_q[0]) begin
               $display("ERROR %0t rd exp %0d got %0d", $time, exp_rd_q[0], rd);
               errors++;
            end
            if (illegal !== exp_ill_q[0]) begin
               $display("ERROR %0t illegal exp %b got %b", $time, exp_ill_q[0], illegal);
               errors++;
            end
            void'(exp_res_q.pop_front());
            void'(exp_rd_q.pop_front());
            void'(exp_ill_q.pop_front());
         end
      end
   end

   initial begin
      #((n_issue_max * 3 + 16 + 100) * 8);
      $display("timeout: instructions still outstanding after the time limit");
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      logic [4:0]  r;
      logic [4:0]  s1;
      logic [4:0]  s2;
      logic [4:0]  last;
      logic [2:0]  f3;
      logic [31:0] t;
      logic [31:0] word;
      logic [11:0] imm;
      logic        alt;
      int          eb;
      rst_n      = 1'b0;
      issue      = 1'b0;
      instr_word = '0;
      pc         = '0;
      last       = '0;
      for (int i = 0; i < 32; i++) begin
         mirror[i] = '0;
      end
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      eb = errors;
      repeat (8) begin
         r = pick_nz();
         s2 = pick_nz();
         t = rnd();
         pc_v = rnd() & ~32'd3;
         send({t[31:12], r, opc_lui}, {t[31:12], 12'b0}, 1'b0, 1'b1);
         send({t[31:12], r, opc_auipc}, pc_v + {t[31:12], 12'b0}, 1'b0, 1'b1);
         send(enc_j({t[20:1], 1'b0}, s2), pc_v + 32'd4, 1'b0, 1'b1);
         send(enc_i(t[11:0], pick_reg(), 3'b000, r, opc_jalr), pc_v + 32'd4, 1'b0, 1'b1);
         // both link registers read back through an add
         send(enc_r(f7_base, s2, r, f3_add, pick_nz()), mirror[r] + mirror[s2],
              1'b0, 1'b1);
      end
      finish_test("upper_imm_and_jumps", eb);

      eb = errors;
      for (int i = 1; i < 32; i++) begin
         t = rnd();
         send(enc_i(t[11:0], 5'd0, f3_add, 5'(i), opc_op_imm), sext12(t[11:0]), 1'b0, 1'b1);
      end
      repeat (n_rand) begin
         t = rnd();
         f3 = t[14:12];
         imm = t[11:0];
         if (f3 == f3_sll) imm[11:5] = f7_base;
         if (f3 == f3_sr) imm[11:5] = t[31] ? f7_alt : f7_base;
         alt = (f3 == f3_sr) && imm[10];
         s1 = pick_reg();
         word = enc_i(imm, s1, f3, pick_nz(), opc_op_imm);
         send(word, ref_int(f3, alt, mirror[s1], sext12(imm)), 1'b0, 1'b1);
      end
      finish_test("reg_imm_ops", eb);

      // back to back, every other one depends on the one before
      eb = errors;
      gaps = 1'b0;
      for (int i = 0; i < n_rand; i++) begin
         t = rnd();
         f3 = t[2:0];
         alt = t[3] && (f3 == f3_add || f3 == f3_sr);
         s1 = (i % 2 == 1) ? last : pick_reg();
         s2 = pick_reg();
         r = pick_nz();
         word = enc_r(alt ? f7_alt : f7_base, s2, s1, f3, r);
         send(word, ref_int(f3, alt, mirror[s1], mirror[s2]), 1'b0, 1'b1);
         last = r;
      end
      gaps = 1'b1;
      finish_test("reg_reg_ops", eb);

      eb = errors;
      repeat (40) begin
         t = rnd();
         f3 = br_f3[$unsigned(t) % 6];
         s1 = pick_reg();
         s2 = t[31] ? s1 : pick_reg();
         word = enc_b({t[12:1], 1'b0}, s2, s1, f3);
         send(word, {31'b0, ref_br(f3, mirror[s1], mirror[s2])}, 1'b0, 1'b0);
         r = word[11:7];
         send(enc_r(f7_base, 5'd0, r, f3_add, pick_nz()), mirror[r], 1'b0, 1'b1);
      end
      finish_test("branches", eb);

      eb = errors;
      send(enc_i(12'h000, 5'd0, f3_add, 5'd1, opc_op_imm), 32'h0, 1'b0, 1'b1);
      send({20'h80000, 5'd2, opc_lui}, 32'h8000_0000, 1'b0, 1'b1);
      send(enc_i(12'hfff, 5'd0, f3_add, 5'd3, opc_op_imm), 32'hffff_ffff, 1'b0, 1'b1);
      for (int k = 4; k < 8; k++) begin
         send(enc_r(f7_muldiv, 5'd3, 5'd2, 3'(k), 5'(10 + k)),
              ref_m(3'(k), mirror[2], mirror[3]), 1'b0, 1'b1);
         send(enc_r(f7_muldiv, 5'd1, 5'd2, 3'(k), 5'(20 + k)),
              ref_m(3'(k), mirror[2], mirror[1]), 1'b0, 1'b1);
      end
      repeat (n_rand) begin
         f3 = 3'(rnd());
         s1 = pick_reg();
         s2 = pick_reg();
         send(enc_r(f7_muldiv, s2, s1, f3, pick_nz()), ref_m(f3, mirror[s1], mirror[s2]),
              1'b0, 1'b1);
      end
      finish_test("mul_div", eb);

      eb = errors;
      repeat (20) begin
         t = rnd();
         s1 = pick_reg();
         f3 = ld_f3[$unsigned(t) % 5];
         send(enc_i(t[31:20], s1, f3, pick_nz(), opc_load), mirror[s1] + sext12(t[31:20]),
              1'b0, 1'b1);
         s1 = pick_reg();
         word = enc_s(t[11:0], pick_reg(), s1, 3'($unsigned(t) % 3));
         send(word, mirror[s1] + sext12(t[11:0]), 1'b0, 1'b0);
         r = word[11:7];
         send({t[31:7], 7'b1111111}, 32'h0, 1'b1, 1'b0);
         s1 = pick_reg();
         send(enc_i(t[11:0], s1, f3_add, 5'd0, opc_op_imm), mirror[s1] + sext12(t[11:0]),
              1'b0, 1'b1);
         // x0 and the store's rd field must both read unchanged
         send(enc_r(f7_base, r, 5'd0, f3_add, pick_nz()), mirror[r], 1'b0, 1'b1);
      end
      finish_test("mem_illegal_x0", eb);

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: dv/exec_assertions.sv
`default_nettype none

module exec_assertions
   import rv_pkg::*;
   (
   input logic                  clk,
   input logic                  rst_n,
   input logic                  issue,
   input logic                  done,
   input logic                  wr_en,
   input logic [reg_addr_w-1:0] wr_addr,
   input logic                  valid,
   input instr_t                instr
   );

   timeunit 1ns;
   timeprecision 100ps;

   // flags sit above imm and pc
   localparam int flag_lo = 2 * xlen;

   a_done_in_reset: assert property (@(posedge clk) !rst_n |=> !done)
      else $error("done high during reset");

   a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
      issue |-> ##2 done)
      else $error("done missing two cycles after issue");

   a_done_cause: assert property (@(posedge clk) disable iff (!rst_n)
      done |-> $past(issue, 2))
      else $error("done without issue two cycles before");

   a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
      wr_en |-> wr_addr != '0)
      else $error("register write to x0");

   a_one_flag: assert property (@(posedge clk) disable iff (!rst_n)
      valid |-> $onehot0(instr[$bits(instr_t)-1:flag_lo]))
      else $error("more than one instruction flag set");

endmodule

bind exec_top exec_assertions u_assertions (
   .clk     (clk),
   .rst_n   (rst_n),
   .issue   (issue),
   .done    (done),
   .wr_en   (wr_en),
   .wr_addr (wr_addr),
   .valid   (dec_bus.valid),
   .instr   (dec_bus.instr)
);

`default_nettype wire

// File: dv/clk_gen.sv
`default_nettype none

module clk_gen (
   output logic clk
   );

   timeunit 1ns;
   timeprecision 100ps;

   initial clk = 1'b0;

   // 8 ns period
   always #4 clk = ~clk;

endmodule

`default_nettype wire

// File: src/exec_top.sv
`default_nettype none

module exec_top
   import rv_pkg::*;
   (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  issue,
   input  logic [xlen-1:0]       instr_word,
   input  logic [xlen-1:0]       pc,
   output logic                  done,
   output logic [xlen-1:0]       result,
   output logic [reg_addr_w-1:0] rd,
   output logic                  illegal
   );

   reg_pair_t             operands;
   logic                  wr_en;
   logic [reg_addr_w-1:0] wr_addr;
   logic [xlen-1:0]       wr_data;

   decode_if dec_bus ();

   instr_decoder u_decoder (
      .clk        (clk),
      .rst_n      (rst_n),
      .issue      (issue),
      .instr_word (instr_word),
      .pc         (pc),
      .dec        (dec_bus.producer)
   );

   reg_file u_reg_file (
      .clk      (clk),
      .rst_n    (rst_n),
      .dec      (dec_bus.consumer),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .operands (operands)
   );

   alu u_alu (
      .clk       (clk),
      .rst_n     (rst_n),
      .dec       (dec_bus.consumer),
      .operands  (operands),
      .completed (done),
      .result    (result),
      .rd        (rd),
      .illegal   (illegal),
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .wr_data   (wr_data)
   );

endmodule

`default_nettype wire

// File: src/alu.sv
`default_nettype none

module alu
   import rv_pkg::*;
   (
   input  logic                  clk,
   input  logic                  rst_n,
   decode_if.consumer            dec,
   input  reg_pair_t             operands,
   output logic                  completed,
   output logic [xlen-1:0]       result,
   output logic [reg_addr_w-1:0] rd,
   output logic                  illegal,
   output logic                  wr_en,
   output logic [reg_addr_w-1:0] wr_addr,
   output logic [xlen-1:0]       wr_data
   );

   instr_t          ins;
   logic [xlen-1:0] rs1;
   logic [xlen-1:0] rs2;
   logic [xlen-1:0] alu_out;

   logic [xlen-1:0] link;
   logic [xlen-1:0] sum_imm;
   logic            is_mem;
   logic            eq;
   logic            lt_s;
   logic            lt_u;
   logic            lt_si;
   logic            lt_ui;

   logic signed [xlen-1:0] sra_imm;
   logic signed [xlen-1:0] sra_reg;
   logic signed [63:0]     mul_ss;
   logic signed [63:0]     mul_su;
   logic [63:0]            mul_uu;

   logic                   div_zero;
   logic                   div_ovf;
   logic signed [xlen-1:0] div_s;
   logic signed [xlen-1:0] rem_s;
   logic [xlen-1:0]        div_q;
   logic [xlen-1:0]        rem_q;
   logic [xlen-1:0]        divu_q;
   logic [xlen-1:0]        remu_q;

   assign ins = dec.instr;
   assign rs1 = operands.rs1;
   assign rs2 = operands.rs2;

   assign link    = ins.pc + 32'd4;
   assign sum_imm = rs1 + ins.imm;
   assign is_mem  = ins.lb | ins.lh | ins.lw | ins.lbu | ins.lhu |
                    ins.sb | ins.sh | ins.sw;

   assign eq    = (rs1 == rs2);
   assign lt_s  = ($signed(rs1) < $signed(rs2));
   assign lt_u  = (rs1 < rs2);
   assign lt_si = ($signed(rs1) < $signed(ins.imm));
   assign lt_ui = (rs1 < ins.imm);

   // kept out of the mux so the signed ops stay signed
   assign sra_imm = $signed(rs1) >>> ins.imm[4:0];
   assign sra_reg = $signed(rs1) >>> rs2[4:0];

   assign mul_ss = $signed({{32{rs1[31]}}, rs1}) * $signed({{32{rs2[31]}}, rs2});
   assign mul_su = $signed({{32{rs1[31]}}, rs1}) * $signed({32'b0, rs2});
   assign mul_uu = {32'b0, rs1} * {32'b0, rs2};

   assign div_zero = (rs2 == '0);
   assign div_ovf  = (rs1 == 32'h8000_0000) && (rs2 == '1);
   assign div_s    = $signed(rs1) / $signed(rs2);
   assign rem_s    = $signed(rs1) % $signed(rs2);

   // RISC-V special cases, no trap
   assign div_q  = div_zero ? '1 : div_ovf ? rs1 : div_s;
   assign rem_q  = div_zero ? rs1 : div_ovf ? '0 : rem_s;
   assign divu_q = div_zero ? '1 : rs1 / rs2;
   assign remu_q = div_zero ? rs1 : rs1 % rs2;

   // one-hot select, nothing set gives zero
   assign alu_out =
      ins.lui    ? ins.imm :
      ins.auipc  ? ins.pc + ins.imm :
      ins.jal    ? link :
      ins.jalr   ? link :
      ins.beq    ? {31'b0, eq} :
      ins.bne    ? {31'b0, !eq} :
      ins.blt    ? {31'b0, lt_s} :
      ins.bge    ? {31'b0, !lt_s} :
      ins.bltu   ? {31'b0, lt_u} :
      ins.bgeu   ? {31'b0, !lt_u} :
      is_mem     ? sum_imm :
      ins.addi   ? sum_imm :
      ins.slti   ? {31'b0, lt_si} :
      ins.sltiu  ? {31'b0, lt_ui} :
      ins.xori   ? rs1 ^ ins.imm :
      ins.ori    ? rs1 | ins.imm :
      ins.andi   ? rs1 & ins.imm :
      ins.slli   ? rs1 << ins.imm[4:0] :
      ins.srli   ? rs1 >> ins.imm[4:0] :
      ins.srai   ? sra_imm :
      ins.add    ? rs1 + rs2 :
      ins.sub    ? rs1 - rs2 :
      ins.sll    ? rs1 << rs2[4:0] :
      ins.slt    ? {31'b0, lt_s} :
      ins.sltu   ? {31'b0, lt_u} :
      ins.i_xor  ? rs1 ^ rs2 :
      ins.srl    ? rs1 >> rs2[4:0] :
      ins.sra    ? sra_reg :
      ins.i_or   ? rs1 | rs2 :
      ins.i_and  ? rs1 & rs2 :
      ins.mul    ? mul_ss[31:0] :
      ins.mulh   ? mul_ss[63:32] :
      ins.mulhsu ? mul_su[63:32] :
      ins.mulhu  ? mul_uu[63:32] :
      ins.div    ? div_q :
      ins.divu   ? divu_q :
      ins.rem    ? rem_q :
      ins.remu   ? remu_q :
      '0;

   // write lands on the same edge that registers the result
   assign wr_en   = dec.valid && dec.writes_rd;
   assign wr_addr = dec.rd_addr;
   assign wr_data = alu_out;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         completed <= 1'b0;
         illegal   <= 1'b0;
      end else begin
         completed <= dec.valid;
         if (dec.valid) begin
            illegal <= dec.illegal;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (dec.valid) begin
         result <= alu_out;
         rd     <= dec.rd_addr;
      end
   end

endmodule

`default_nettype wire

// File: src/reg_file.sv
`default_nettype none

module reg_file
   import rv_pkg::*;
   (
   input  logic                  clk,
   input  logic                  rst_n,
   decode_if.consumer            dec,
   input  logic                  wr_en,
   input  logic [reg_addr_w-1:0] wr_addr,
   input  logic [xlen-1:0]       wr_data,
   output reg_pair_t             operands
   );

   logic [xlen-1:0] regs [reg_count];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && (wr_addr != '0)) begin
         // x0 never written, stays zero from reset
         regs[wr_addr] <= wr_data;
      end
   end

   // combinational reads, a write on this edge is visible next cycle
   assign operands.rs1 = regs[dec.rs1_addr];
   assign operands.rs2 = regs[dec.rs2_addr];

endmodule

`default_nettype wire

// File: src/instr_decoder.sv
`default_nettype none

module instr_decoder
   import rv_pkg::*;
   (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            issue,
   input  logic [xlen-1:0] instr_word,
   input  logic [xlen-1:0] pc,
   decode_if.producer      dec
   );

   logic            valid_q;
   logic [xlen-1:0] word_q;
   logic [xlen-1:0] pc_q;

   logic [6:0]            opcode;
   logic [2:0]            f3;
   logic [6:0]            f7;
   logic [reg_addr_w-1:0] rd;
   logic [xlen-1:0]       imm_i;
   logic [xlen-1:0]       imm_s;
   logic [xlen-1:0]       imm_b;
   logic [xlen-1:0]       imm_u;
   logic [xlen-1:0]       imm_j;

   instr_t d;
   logic   ill;
   logic   wr;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= issue;
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         word_q <= instr_word;
         pc_q   <= pc;
      end
   end

   assign opcode = word_q[6:0];
   assign rd     = word_q[11:7];
   assign f3     = word_q[14:12];
   assign f7     = word_q[31:25];

   // sign-extended immediates per format
   assign imm_i = {{20{word_q[31]}}, word_q[31:20]};
   assign imm_s = {{20{word_q[31]}}, word_q[31:25], word_q[11:7]};
   assign imm_b = {{19{word_q[31]}}, word_q[31], word_q[7], word_q[30:25],
                   word_q[11:8], 1'b0};
   assign imm_u = {word_q[31:12], 12'b0};
   assign imm_j = {{11{word_q[31]}}, word_q[31], word_q[19:12], word_q[20],
                   word_q[30:21], 1'b0};

   always_comb begin
      d     = '0;
      d.pc  = pc_q;
      ill   = 1'b0;
      wr    = 1'b0;
      case (opcode)
         opc_lui: begin
            d.lui = 1'b1;
            d.imm = imm_u;
            wr    = 1'b1;
         end
         opc_auipc: begin
            d.auipc = 1'b1;
            d.imm   = imm_u;
            wr      = 1'b1;
         end
         opc_jal: begin
            d.jal = 1'b1;
            d.imm = imm_j;
            wr    = 1'b1;
         end
         opc_jalr: begin
            d.jalr = (f3 == 3'b000);
            ill    = (f3 != 3'b000);
            d.imm  = imm_i;
            wr     = 1'b1;
         end
         opc_branch: begin
            d.imm  = imm_b;
            d.beq  = (f3 == f3_beq);
            d.bne  = (f3 == f3_bne);
            d.blt  = (f3 == f3_blt);
            d.bge  = (f3 == f3_bge);
            d.bltu = (f3 == f3_bltu);
            d.bgeu = (f3 == f3_bgeu);
            ill    = (f3 == 3'b010) || (f3 == 3'b011);
         end
         opc_load: begin
            d.imm = imm_i;
            d.lb  = (f3 == f3_lb);
            d.lh  = (f3 == f3_lh);
            d.lw  = (f3 == f3_lw);
            d.lbu = (f3 == f3_lbu);
            d.lhu = (f3 == f3_lhu);
            ill   = (f3 == 3'b011) || (f3 == 3'b110) || (f3 == 3'b111);
            wr    = 1'b1;
         end
         opc_store: begin
            d.imm = imm_s;
            d.sb  = (f3 == f3_sb);
            d.sh  = (f3 == f3_sh);
            d.sw  = (f3 == f3_sw);
            ill   = (f3[2] || f3 == 3'b011);
         end
         opc_op_imm: begin
            d.imm   = imm_i;
            wr      = 1'b1;
            d.addi  = (f3 == f3_add);
            d.slti  = (f3 == f3_slt);
            d.sltiu = (f3 == f3_sltu);
            d.xori  = (f3 == f3_xor);
            d.ori   = (f3 == f3_or);
            d.andi  = (f3 == f3_and);
            d.slli  = (f3 == f3_sll) && (f7 == f7_base);
            d.srli  = (f3 == f3_sr) && (f7 == f7_base);
            d.srai  = (f3 == f3_sr) && (f7 == f7_alt);
            // shift immediates only allow the base or alt funct7
            ill     = (f3 == f3_sll && f7 != f7_base) ||
                      (f3 == f3_sr && f7 != f7_base && f7 != f7_alt);
         end
         opc_op: begin
            wr = 1'b1;
            case (f7)
               f7_base: begin
                  d.add   = (f3 == f3_add);
                  d.sll   = (f3 == f3_sll);
                  d.slt   = (f3 == f3_slt);
                  d.sltu  = (f3 == f3_sltu);
                  d.i_xor = (f3 == f3_xor);
                  d.srl   = (f3 == f3_sr);
                  d.i_or  = (f3 == f3_or);
                  d.i_and = (f3 == f3_and);
               end
               f7_alt: begin
                  d.sub = (f3 == f3_add);
                  d.sra = (f3 == f3_sr);
                  ill   = (f3 != f3_add) && (f3 != f3_sr);
               end
               f7_muldiv: begin
                  d.mul    = (f3 == f3_mul);
                  d.mulh   = (f3 == f3_mulh);
                  d.mulhsu = (f3 == f3_mulhsu);
                  d.mulhu  = (f3 == f3_mulhu);
                  d.div    = (f3 == f3_div);
                  d.divu   = (f3 == f3_divu);
                  d.rem    = (f3 == f3_rem);
                  d.remu   = (f3 == f3_remu);
               end
               default: ill = 1'b1;
            endcase
         end
         default: ill = 1'b1;
      endcase
   end

   assign dec.valid     = valid_q;
   assign dec.instr     = d;
   assign dec.rs1_addr  = word_q[19:15];
   assign dec.rs2_addr  = word_q[24:20];
   assign dec.rd_addr   = rd;
   assign dec.writes_rd = wr && !ill && (rd != '0);
   assign dec.illegal   = ill;

endmodule

`default_nettype wire

// File: src/decode_if.sv
`default_nettype none

interface decode_if
   import rv_pkg::*;
   ();

   logic                  valid;
   instr_t                instr;
   logic [reg_addr_w-1:0] rs1_addr;
   logic [reg_addr_w-1:0] rs2_addr;
   logic [reg_addr_w-1:0] rd_addr;
   logic                  writes_rd;
   logic                  illegal;

   modport producer (
      output valid, instr, rs1_addr, rs2_addr, rd_addr, writes_rd, illegal
   );

   modport consumer (
      input valid, instr, rs1_addr, rs2_addr, rd_addr, writes_rd, illegal
   );

endinterface

`default_nettype wire

// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

   localparam int xlen = 32;
   localparam int reg_count = 32;
   localparam int reg_addr_w = 5;

   // major opcodes
   localparam logic [6:0] opc_lui    = 7'b0110111;
   localparam logic [6:0] opc_auipc  = 7'b0010111;
   localparam logic [6:0] opc_jal    = 7'b1101111;
   localparam logic [6:0] opc_jalr   = 7'b1100111;
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_load   = 7'b0000011;
   localparam logic [6:0] opc_store  = 7'b0100011;
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_op     = 7'b0110011;

   // branch funct3
   localparam logic [2:0] f3_beq  = 3'b000;
   localparam logic [2:0] f3_bne  = 3'b001;
   localparam logic [2:0] f3_blt  = 3'b100;
   localparam logic [2:0] f3_bge  = 3'b101;
   localparam logic [2:0] f3_bltu = 3'b110;
   localparam logic [2:0] f3_bgeu = 3'b111;

   // load and store widths
   localparam logic [2:0] f3_lb  = 3'b000;
   localparam logic [2:0] f3_lh  = 3'b001;
   localparam logic [2:0] f3_lw  = 3'b010;
   localparam logic [2:0] f3_lbu = 3'b100;
   localparam logic [2:0] f3_lhu = 3'b101;
   localparam logic [2:0] f3_sb  = 3'b000;
   localparam logic [2:0] f3_sh  = 3'b001;
   localparam logic [2:0] f3_sw  = 3'b010;

   // integer ops, shared by op and op_imm
   localparam logic [2:0] f3_add  = 3'b000;
   localparam logic [2:0] f3_sll  = 3'b001;
   localparam logic [2:0] f3_slt  = 3'b010;
   localparam logic [2:0] f3_sltu = 3'b011;
   localparam logic [2:0] f3_xor  = 3'b100;
   localparam logic [2:0] f3_sr   = 3'b101;
   localparam logic [2:0] f3_or   = 3'b110;
   localparam logic [2:0] f3_and  = 3'b111;

   // M extension
   localparam logic [2:0] f3_mul    = 3'b000;
   localparam logic [2:0] f3_mulh   = 3'b001;
   localparam logic [2:0] f3_mulhsu = 3'b010;
   localparam logic [2:0] f3_mulhu  = 3'b011;
   localparam logic [2:0] f3_div    = 3'b100;
   localparam logic [2:0] f3_divu   = 3'b101;
   localparam logic [2:0] f3_rem    = 3'b110;
   localparam logic [2:0] f3_remu   = 3'b111;

   localparam logic [6:0] f7_base   = 7'b0000000;
   localparam logic [6:0] f7_alt    = 7'b0100000;
   localparam logic [6:0] f7_muldiv = 7'b0000001;

   // one flag per instruction, at most one set
   typedef struct packed {
      logic lui, auipc;
      logic jal, jalr;
      logic beq, bne, blt, bge, bltu, bgeu;
      logic lb, lh, lw, lbu, lhu;
      logic sb, sh, sw;
      logic addi, slti, sltiu, xori, ori, andi;
      logic slli, srli, srai;
      logic add, sub, sll, slt, sltu, i_xor;
      logic srl, sra, i_or, i_and;
      logic mul, mulh, mulhsu, mulhu;
      logic div, divu, rem, remu;
      logic [xlen-1:0] imm;
      logic [xlen-1:0] pc;
   } instr_t;

   typedef struct packed {
      logic [xlen-1:0] rs1;
      logic [xlen-1:0] rs2;
   } reg_pair_t;

endpackage

`default_nettype wire
